// File: build.f
+incdir+hw
hw/grid_pkg.sv
hw/particle_pkg.sv
hw/field_if.sv
hw/gyro_stencil.sv
hw/efield_diff.sv
hw/drift_update.sv
hw/pusher_top.sv
dv/pusher_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the pusher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module pusher_tb \
    -f build.f \
    -Mdir obj_dir -o pusher_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile step failed with status $status"
    exit 1
fi

./obj_dir/pusher_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// File: dv/pusher_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "pusher_cfg.svh"

module pusher_tb;

    localparam int LAT = `RD_LAT + 7;
    localparam int TIMEOUT = 200;
    localparam int MODE_CONST = 0;
    localparam int MODE_LINEAR = 1;
    localparam int MODE_HASH = 2;

    logic                    clk;
    logic                    rst_ff;
    logic                    valid;
    logic                    noop;
    particle_pkg::particle_t particle_in;
    grid_pkg::stencil_phi_t  phi_in;
    logic                    valid_req;
    grid_pkg::stencil_addr_t raddr;
    logic                    valid_out;
    particle_pkg::particle_t particle_out;
    logic                    done;

    int                      phi_mode;
    int                      slope;           // potential step per cell in linear mode
    logic [31:0]             rand_state;
    grid_pkg::stencil_addr_t mem_addr [`RD_LAT+1];

    pusher_top i_dut (
        .clk          (clk),
        .rst_ff       (rst_ff),
        .valid        (valid),
        .noop         (noop),
        .particle_in  (particle_in),
        .phi_in       (phi_in),
        .valid_req    (valid_req),
        .raddr        (raddr),
        .valid_out    (valid_out),
        .particle_out (particle_out),
        .done         (done)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // potential grid and random source
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rand_state = lfsr_step(rand_state);
            v[i] = rand_state[0];
        end
        return v;
    endfunction

    function automatic grid_pkg::phi_t phi_of(grid_pkg::grid_addr_t a);
        logic [31:0]    s;
        grid_pkg::phi_t v;
        case (phi_mode)
            MODE_CONST:  return grid_pkg::phi_t'(300);
            MODE_LINEAR: return grid_pkg::phi_t'(slope * (int'(a[`PINT-1:0]) - 128));
            default: begin
                s = 32'h83bd0901 ^ {16'h0, a};    // whole address feeds the hash
                for (int i = 0; i < `PHI_W; i++) begin
                    s = lfsr_step(s);
                    v[i] = s[0];
                end
                return v;
            end
        endcase
    endfunction

    // grid memory, RD_LAT cycles from request to data
    initial begin
        phi_in = '0;
        forever begin
            @(posedge clk);
            #2;
            for (int k = `RD_LAT; k > 0; k--) begin
                mem_addr[k] = mem_addr[k-1];
            end
            mem_addr[0] = raddr;   // address registered at this edge
            for (int g = 0; g < 4; g++) begin
                for (int n = 0; n < 4; n++) begin
                    phi_in[g][n] = phi_of(mem_addr[`RD_LAT][g][n]);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // gyropoints 0..3 are left, right, below, above
    function automatic grid_pkg::stencil_addr_t expected_raddr(particle_pkg::particle_t p);
        logic [15:0]             r;
        grid_pkg::coord_u        gy [4];
        grid_pkg::coord_u        gx [4];
        logic [`PINT-1:0]        yw;
        logic [`PINT-1:0]        xw;
        grid_pkg::stencil_addr_t a;
        r = p.vperp >> `GYRO_SHIFT;
        gy[0].raw = p.pos_y.raw;
        gx[0].raw = p.pos_x.raw - r;
        gy[1].raw = p.pos_y.raw;
        gx[1].raw = p.pos_x.raw + r;
        gy[2].raw = p.pos_y.raw - r;
        gx[2].raw = p.pos_x.raw;
        gy[3].raw = p.pos_y.raw + r;
        gx[3].raw = p.pos_x.raw;
        for (int g = 0; g < 4; g++) begin
            yw = gy[g].part.whole;
            xw = gx[g].part.whole;
            a[g][0] = {`PINT'(yw + 1), xw};
            a[g][1] = {`PINT'(yw - 1), xw};
            a[g][2] = {yw, `PINT'(xw + 1)};
            a[g][3] = {yw, `PINT'(xw - 1)};
        end
        return a;
    endfunction

    function automatic particle_pkg::particle_t expected_push(particle_pkg::particle_t p,
                                                              logic nop);
        grid_pkg::stencil_addr_t a;
        particle_pkg::particle_t q;
        int                      sum_y;
        int                      sum_x;
        a = expected_raddr(p);
        sum_y = 0;
        sum_x = 0;
        for (int g = 0; g < 4; g++) begin
            sum_y += (int'(phi_of(a[g][0])) - int'(phi_of(a[g][1]))) >>> 1;
            sum_x += (int'(phi_of(a[g][2])) - int'(phi_of(a[g][3]))) >>> 1;
        end
        q = p;
        if (!nop) begin
            q.pos_y.raw = p.pos_y.raw + 16'((sum_x >>> 2) >>> `SLOWDOWN);
            q.pos_x.raw = p.pos_x.raw - 16'((sum_y >>> 2) >>> `SLOWDOWN);
        end
        return q;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_particle(input particle_pkg::particle_t got,
                                    input particle_pkg::particle_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_addr(input grid_pkg::stencil_addr_t got,
                                input grid_pkg::stencil_addr_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst_ff = 1'b1;
        valid = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_ff = 1'b0;
    endtask

    // one particle through the pipe, raddr checked on the way
    task automatic push_one(input particle_pkg::particle_t p,
                            output particle_pkg::particle_t got);
        int  cycles;
        logic req_seen;
        valid = 1'b1;
        particle_in = p;
        next_cycle();
        valid = 1'b0;
        cycles = 1;
        req_seen = 1'b0;
        while (!valid_out && cycles < TIMEOUT) begin
            if (valid_req) begin
                compare_addr(raddr, expected_raddr(p), "raddr");
                req_seen = 1'b1;
            end
            next_cycle();
            cycles++;
        end
        if (!valid_out) begin
            stop_run($sformatf("no particle came out within %0d cycles", TIMEOUT));
        end
        if (!req_seen) begin
            stop_run("the particle issued no grid read request");
        end
        if (cycles != LAT) begin
            stop_run($sformatf("particle took %0d cycles instead of %0d", cycles, LAT));
        end
        got = particle_out;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_outputs_low();
        compare_bit(valid_req, 1'b0, "valid_req");
        compare_bit(valid_out, 1'b0, "valid_out");
        compare_bit(done, 1'b0, "done");
    endtask

    task automatic constant_potential();
        particle_pkg::particle_t p;
        particle_pkg::particle_t got;
        phi_mode = MODE_CONST;
        p = {16'h2a80, 16'hf310, 16'h0520};
        push_one(p, got);
        compare_particle(got, p, "particle_out");    // flat potential, no drift
    endtask

    task automatic linear_drift(input int s);
        particle_pkg::particle_t p;
        particle_pkg::particle_t got;
        particle_pkg::particle_t exp;
        phi_mode = MODE_LINEAR;
        slope = s;
        p = {16'h4080, 16'h6040, 16'h0300};
        exp = p;
        exp.pos_y.raw = p.pos_y.raw + 16'(s >>> `SLOWDOWN);   // E_x = slope, E_y = 0
        push_one(p, got);
        compare_particle(got, exp, "particle_out");
    endtask

    task automatic noop_holds_position();
        particle_pkg::particle_t p;
        particle_pkg::particle_t got;
        phi_mode = MODE_LINEAR;
        slope = 15;
        noop = 1'b1;
        p = {16'h7110, 16'h5508, 16'h0400};
        push_one(p, got);
        compare_particle(got, p, "particle_out");
        noop = 1'b0;
    endtask

    task automatic random_batch();
        particle_pkg::particle_t ps  [`NUM_PARTICLES];
        particle_pkg::particle_t exp [`NUM_PARTICLES];
        int in_idx;
        int out_idx;
        int cycles;
        phi_mode = MODE_HASH;
        for (int i = 0; i < `NUM_PARTICLES; i++) begin
            ps[i].pos_y.raw = rand_bits(16);
            ps[i].pos_x.raw = rand_bits(16);
            ps[i].vperp = rand_bits(16);
            exp[i] = expected_push(ps[i], 1'b0);
        end
        in_idx = 0;
        out_idx = 0;
        cycles = 0;
        while (out_idx < `NUM_PARTICLES && cycles < TIMEOUT) begin
            if (out_idx > 0) begin
                compare_bit(valid_out, 1'b1, "valid_out");   // back to back out
            end
            compare_bit(done, out_idx == `NUM_PARTICLES - 1, "done");
            if (valid_out) begin
                compare_particle(particle_out, exp[out_idx], "particle_out");
                out_idx++;
            end
            valid = (in_idx < `NUM_PARTICLES);
            if (valid) begin
                particle_in = ps[in_idx];
                in_idx++;
            end
            next_cycle();
            cycles++;
        end
        if (out_idx < `NUM_PARTICLES) begin
            stop_run($sformatf("only %0d of %0d particles came out", out_idx, `NUM_PARTICLES));
        end
    endtask

    initial begin
        rst_ff = 1'b1;
        valid = 1'b0;
        noop = 1'b0;
        particle_in = '0;
        phi_mode = MODE_CONST;
        slope = 0;
        rand_state = 32'h83bd0901;
        apply_reset();
        reset_outputs_low();
        constant_potential();
        linear_drift(15);
        linear_drift(-15);
        noop_holds_position();
        apply_reset();      // fresh batch count
        random_batch();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/pusher_top.sv
`timescale 1ns/10ps
`default_nettype none

module pusher_top (
    input  logic                    clk,
    input  logic                    rst_ff,
    input  logic                    valid,
    input  logic                    noop,
    input  particle_pkg::particle_t particle_in,
    input  grid_pkg::stencil_phi_t  phi_in,
    output logic                    valid_req,
    output grid_pkg::stencil_addr_t raddr,
    output logic                    valid_out,
    output particle_pkg::particle_t particle_out,
    output logic                    done
);

    logic                     valid_dec;
    particle_pkg::particle_t  particle_dec;

    field_if i_field_if ();

    ////////////////////////////////////////////////////////////
    // decode, execute, result
    ////////////////////////////////////////////////////////////

    gyro_stencil i_stencil (
        .clk          (clk),
        .rst_ff       (rst_ff),
        .valid        (valid),
        .particle_in  (particle_in),
        .valid_req    (valid_req),
        .raddr        (raddr),
        .valid_dec    (valid_dec),
        .particle_dec (particle_dec)
    );

    // potentials come back from grid memory RD_LAT after valid_req
    efield_diff i_efield (
        .clk          (clk),
        .rst_ff       (rst_ff),
        .valid_dec    (valid_dec),
        .particle_dec (particle_dec),
        .phi_in       (phi_in),
        .field        (i_field_if)
    );

    drift_update i_drift (
        .clk          (clk),
        .rst_ff       (rst_ff),
        .noop         (noop),
        .field        (i_field_if),
        .valid_out    (valid_out),
        .particle_out (particle_out),
        .done         (done)
    );

endmodule

`default_nettype wire

// File: hw/drift_update.sv
`timescale 1ns/10ps
`default_nettype none
`include "pusher_cfg.svh"

module drift_update (
    input  logic                    clk,
    input  logic                    rst_ff,
    input  logic                    noop,
    field_if.field_snk              field,
    output logic                    valid_out,
    output particle_pkg::particle_t particle_out,
    output logic                    done
);

    localparam int CNT_W = $clog2(`NUM_PARTICLES);

    logic                       valid_pair;
    logic                       valid_push;
    logic signed [`PHI_W+1:0]   pair_y [2];
    logic signed [`PHI_W+1:0]   pair_x [2];
    particle_pkg::particle_t    particle_pair;
    particle_pkg::particle_t    particle_push;
    grid_pkg::field_sum_t       sum_y;
    grid_pkg::field_sum_t       sum_x;
    grid_pkg::field_sum_t       avg_y;
    grid_pkg::field_sum_t       avg_x;
    logic signed [15:0]         step_y;
    logic signed [15:0]         step_x;
    logic [CNT_W-1:0]           cnt;

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_pair <= 1'b0;
            valid_push <= 1'b0;
            valid_out  <= 1'b0;
        end else begin
            valid_pair <= field.valid;
            valid_push <= valid_pair;
            valid_out  <= valid_push;
        end
    end

    ////////////////////////////////////////////////////////////
    // adder tree, first level
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        particle_pair <= field.particle;
        pair_y[0] <= field.efield_y[0] + field.efield_y[1];
        pair_y[1] <= field.efield_y[2] + field.efield_y[3];
        pair_x[0] <= field.efield_x[0] + field.efield_x[1];
        pair_x[1] <= field.efield_x[2] + field.efield_x[3];
    end

    ////////////////////////////////////////////////////////////
    // second level and E x B push
    ////////////////////////////////////////////////////////////

    assign sum_y = pair_y[0] + pair_y[1];
    assign sum_x = pair_x[0] + pair_x[1];
    assign avg_y = sum_y >>> 2;   // mean over 4 gyropoints
    assign avg_x = sum_x >>> 2;

    // B along z: axes swap and x takes the minus sign
    assign step_y = avg_x >>> `SLOWDOWN;
    assign step_x = -(avg_y >>> `SLOWDOWN);

    always_ff @(posedge clk) begin
        particle_push.vperp <= particle_pair.vperp;
        if (noop) begin
            particle_push.pos_y <= particle_pair.pos_y;
            particle_push.pos_x <= particle_pair.pos_x;
        end else begin
            // overflow is the periodic boundary
            particle_push.pos_y.raw <= particle_pair.pos_y.raw + step_y;
            particle_push.pos_x.raw <= particle_pair.pos_x.raw + step_x;
        end
    end

    always_ff @(posedge clk) begin
        particle_out <= particle_push;
    end

    // batch counter, counts particles already out
    always_ff @(posedge clk) begin
        if (rst_ff) begin
            cnt <= '0;
        end else if (valid_out) begin
            cnt <= (cnt == CNT_W'(`NUM_PARTICLES - 1)) ? '0 : cnt + 1'b1;
        end
    end

    assign done = (cnt == CNT_W'(`NUM_PARTICLES - 1));

    a_no_done_after_reset : assert property (@(posedge clk)
        $past(rst_ff) |-> !done);

endmodule

`default_nettype wire

// File: hw/efield_diff.sv
`timescale 1ns/10ps
`default_nettype none
`include "pusher_cfg.svh"

module efield_diff (
    input  logic                    clk,
    input  logic                    rst_ff,
    input  logic                    valid_dec,
    input  particle_pkg::particle_t particle_dec,
    input  grid_pkg::stencil_phi_t  phi_in,
    field_if.field_src              field
);

    logic [`RD_LAT-1:0]       valid_dly;
    particle_pkg::particle_t  particle_dly [`RD_LAT];
    logic                     cap_valid;
    grid_pkg::stencil_phi_t   phi_cap;
    particle_pkg::particle_t  particle_cap;

    // central difference over two cells, halved
    function automatic grid_pkg::efield_t half_diff(grid_pkg::phi_t hi, grid_pkg::phi_t lo);
        grid_pkg::efield_t hi_ext;
        grid_pkg::efield_t lo_ext;
        hi_ext = {hi[`PHI_W-1], hi};
        lo_ext = {lo[`PHI_W-1], lo};
        return (hi_ext - lo_ext) >>> 1;
    endfunction

    ////////////////////////////////////////////////////////////
    // wait out the grid memory, then capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_dly <= '0;
            cap_valid <= 1'b0;
        end else begin
            valid_dly[0] <= valid_dec;
            for (int k = 1; k < `RD_LAT; k++) begin
                valid_dly[k] <= valid_dly[k-1];
            end
            cap_valid <= valid_dly[`RD_LAT-1];
        end
    end

    always_ff @(posedge clk) begin
        particle_dly[0] <= particle_dec;
        for (int k = 1; k < `RD_LAT; k++) begin
            particle_dly[k] <= particle_dly[k-1];
        end
        if (valid_dly[`RD_LAT-1]) begin
            phi_cap      <= phi_in;   // samples for this particle's raddr
            particle_cap <= particle_dly[`RD_LAT-1];
        end
    end

    // field per gyropoint
    always_ff @(posedge clk) begin
        if (rst_ff) begin
            field.valid <= 1'b0;
        end else begin
            field.valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            field.particle <= particle_cap;
            for (int g = 0; g < 4; g++) begin
                field.efield_y[g] <= half_diff(phi_cap[g][grid_pkg::NB_YP],
                                               phi_cap[g][grid_pkg::NB_YM]);
                field.efield_x[g] <= half_diff(phi_cap[g][grid_pkg::NB_XP],
                                               phi_cap[g][grid_pkg::NB_XM]);
            end
        end
    end

    a_field_has_sample : assert property (@(posedge clk) disable iff (rst_ff)
        $rose(field.valid) |-> $past(valid_dly[`RD_LAT-1], 2));

endmodule

`default_nettype wire

// File: hw/gyro_stencil.sv
`timescale 1ns/10ps
`default_nettype none
`include "pusher_cfg.svh"

module gyro_stencil (
    input  logic                    clk,
    input  logic                    rst_ff,
    input  logic                    valid,
    input  particle_pkg::particle_t particle_in,
    output logic                    valid_req,
    output grid_pkg::stencil_addr_t raddr,
    output logic                    valid_dec,
    output particle_pkg::particle_t particle_dec
);

    logic [15:0]              gyroradius;
    grid_pkg::coord_u [3:0]   gp_y;
    grid_pkg::coord_u [3:0]   gp_x;
    logic                     valid_gp;
    particle_pkg::particle_t  particle_gp;

    assign gyroradius = particle_in.vperp >> `GYRO_SHIFT;  // uniform B, normalised

    ////////////////////////////////////////////////////////////
    // stage 1: four gyropoints around the particle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_gp <= 1'b0;
        end else begin
            valid_gp <= valid;
        end
    end

    // raw adds wrap at the grid edge
    always_ff @(posedge clk) begin
        particle_gp <= particle_in;
        gp_y[0].raw <= particle_in.pos_y.raw;
        gp_x[0].raw <= particle_in.pos_x.raw - gyroradius;    // left
        gp_y[1].raw <= particle_in.pos_y.raw;
        gp_x[1].raw <= particle_in.pos_x.raw + gyroradius;    // right
        gp_y[2].raw <= particle_in.pos_y.raw - gyroradius;    // below
        gp_x[2].raw <= particle_in.pos_x.raw;
        gp_y[3].raw <= particle_in.pos_y.raw + gyroradius;    // above
        gp_x[3].raw <= particle_in.pos_x.raw;
    end

    ////////////////////////////////////////////////////////////
    // stage 2: neighbour addresses of each gyropoint node
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_req <= 1'b0;
        end else begin
            valid_req <= valid_gp;
        end
    end

    always_ff @(posedge clk) begin
        particle_dec <= particle_gp;
        for (int g = 0; g < 4; g++) begin
            raddr[g][grid_pkg::NB_YP] <= {gp_y[g].part.whole + 1'b1, gp_x[g].part.whole};
            raddr[g][grid_pkg::NB_YM] <= {gp_y[g].part.whole - 1'b1, gp_x[g].part.whole};
            raddr[g][grid_pkg::NB_XP] <= {gp_y[g].part.whole, gp_x[g].part.whole + 1'b1};
            raddr[g][grid_pkg::NB_XM] <= {gp_y[g].part.whole, gp_x[g].part.whole - 1'b1};
        end
    end

    assign valid_dec = valid_req;  // particle travels with the request

    // request strobe is the input strobe two stages later
    a_req_latency : assert property (@(posedge clk)
        !$past(rst_ff) && !$past(rst_ff, 2) |-> valid_req == $past(valid, 2));

endmodule

`default_nettype wire

// File: hw/field_if.sv
`timescale 1ns/10ps
`default_nettype none

interface field_if;
    logic                      valid;
    particle_pkg::particle_t   particle;
    grid_pkg::efield_t [3:0]   efield_y;   // one per gyropoint
    grid_pkg::efield_t [3:0]   efield_x;

    modport field_src (output valid, output particle, output efield_y, output efield_x);
    modport field_snk (input valid, input particle, input efield_y, input efield_x);
endinterface

`default_nettype wire

// File: hw/particle_pkg.sv
`default_nettype none

package particle_pkg;

    // 48 bits, same layout as the memory word of a particle
    typedef struct packed {
        grid_pkg::coord_u pos_y;
        grid_pkg::coord_u pos_x;
        logic [15:0]      vperp;
    } particle_t;

endpackage

`default_nettype wire

// File: hw/grid_pkg.sv
`default_nettype none
`include "pusher_cfg.svh"

package grid_pkg;

    // whole part on top so the raw word adds like a plain fixed-point number
    typedef struct packed {
        logic [`PINT-1:0]  whole;
        logic [`PFRAC-1:0] frac;
    } coord_parts_t;

    typedef union packed {
        logic [`PINT+`PFRAC-1:0] raw;   // for wrapping adds
        coord_parts_t            part;  // for addressing
    } coord_u;

    typedef logic [15:0] grid_addr_t;               // {y whole, x whole}
    typedef logic signed [`PHI_W-1:0] phi_t;
    typedef logic signed [`PHI_W:0] efield_t;       // one central difference
    typedef logic signed [`PHI_W+2:0] field_sum_t;  // four differences

    // neighbour slots inside a gyropoint
    localparam int NB_YP = 0;
    localparam int NB_YM = 1;
    localparam int NB_XP = 2;
    localparam int NB_XM = 3;

    typedef grid_addr_t [3:0][3:0] stencil_addr_t;  // [gyropoint][neighbour]
    typedef phi_t [3:0][3:0] stencil_phi_t;

endpackage

`default_nettype wire

// File: hw/pusher_cfg.svh
`ifndef PUSHER_CFG_SVH
`define PUSHER_CFG_SVH

////////////////////////////////////////////////////////////
// coordinate format
////////////////////////////////////////////////////////////

`define PINT 8          // whole grid cells
`define PFRAC 8         // sub-cell fraction

////////////////////////////////////////////////////////////
// field and drift scaling
////////////////////////////////////////////////////////////

`define PHI_W 12        // signed potential sample
`define GYRO_SHIFT 2    // vperp >> this gives the gyroradius
`define SLOWDOWN 3      // averaged field >> this gives the step

////////////////////////////////////////////////////////////
// memory and batch
////////////////////////////////////////////////////////////

`define RD_LAT 2        // grid memory read latency
`define NUM_PARTICLES 16

`endif
